// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scc_player -f tb.f -o sim_tb

out="$(./obj_dir/sim_tb 2>&1)" || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test passed'; then
    exit 0
fi
exit 1

// ==== tb.f ====
+incdir+testbench
verilog/scc_bus_pkg.sv
verilog/scc_voice_pkg.sv
verilog/scc_reg_decode.sv
verilog/scc_wave_ram.sv
verilog/scc_voice.sv
verilog/scc_mixer.sv
verilog/scc_player.sv
testbench/scc_player_props.sv
testbench/tb_scc_player.sv

// ==== testbench/scc_player_props.sv ====
`default_nettype none

module scc_player_props (
    input logic                                   emuclk,
    input logic                                   rst_n,
    input logic                                   i_rd,
    input logic [scc_voice_pkg::NUM_VOICES-1:0]   i_mute_n,
    input logic [scc_bus_pkg::DATA_W-1:0]         i_db,
    input logic signed [scc_voice_pkg::MIX_W-1:0] i_sound
);

    timeunit 1ns;
    timeprecision 100ps;

    // All voices muted for three edges, so the pipe holds only zeros
    a_muted_silent: assert property (@(posedge emuclk) disable iff (!rst_n)
        (i_mute_n == '0 && $past(i_mute_n) == '0 && $past(i_mute_n, 2) == '0)
        |-> (i_sound == '0))
        else $error("o_sound not zero while all voices are muted");

    // Three voices of -120..119 each
    a_sound_range: assert property (@(posedge emuclk) disable iff (!rst_n)
        (i_sound >= -360 && i_sound <= 357))
        else $error("o_sound out of range: %0d", i_sound);

    a_db_hold: assert property (@(posedge emuclk) disable iff (!rst_n)
        !$stable(i_db) |-> $past(i_rd, 2))
        else $error("o_db changed without a read two cycles earlier");

endmodule

`default_nettype wire

// ==== testbench/tb_scc_tests.svh ====
`ifndef TB_SCC_TESTS_SVH
`define TB_SCC_TESTS_SVH

// Table level and volume per voice for the mix tests
logic [SAMPLE_W-1:0] mix_level [NUM_VOICES] = '{8'h50, 8'h9C, 8'h7F};
logic [VOL_W-1:0]    mix_vol   [NUM_VOICES] = '{4'd12, 4'd9, 4'd15};

function automatic logic signed [MIX_W-1:0] expected_mix(input logic [NUM_VOICES-1:0] en);
    int total;
    total = 0;
    for (int v = 0; v < NUM_VOICES; v++) begin
        total += scaled_value(mix_level[v], mix_vol[v], en[v]);
    end
    return MIX_W'(total);
endfunction

////////////////////////////////////////
// Waits on o_sound

task automatic wait_sound_value(input logic signed [MIX_W-1:0] exp, input int limit);
    int cycles;
    cycles = 0;
    while (o_sound !== exp && cycles < limit) begin
        @(posedge emuclk);
        #10;
        cycles++;
    end
    if (o_sound !== exp) begin
        n_errors++;
        $display("%s: o_sound did not settle to %0d within %0d cycles", cur_test, exp, limit);
    end
endtask

task automatic wait_sound_change(input int limit, output int cycles);
    logic signed [MIX_W-1:0] prev;
    prev   = o_sound;
    cycles = 0;
    while (o_sound === prev && cycles < limit) begin
        @(posedge emuclk);
        #10;
        cycles++;
    end
    if (o_sound === prev) begin
        n_errors++;
        $display("%s: o_sound did not change within %0d cycles", cur_test, limit);
    end
endtask

////////////////////////////////////////
// Directed tests

task automatic test_reset_state();
    logic [DATA_W-1:0] rd;
    start_test("reset_state");
    check_sound("o_sound after reset", '0, o_sound);
    check_byte("o_db after reset", '0, o_db);
    read_reg(reg_addr(SEL_VOL), rd);
    check_byte("read of 0x8A", 8'h00, rd);
    end_test();
endtask

task automatic test_wave_readback();
    logic [DATA_W-1:0] expected [NUM_VOICES][WAVE_DEPTH];
    logic [DATA_W-1:0] rd;
    start_test("wave_readback");
    for (int v = 0; v < NUM_VOICES; v++) begin
        for (int i = 0; i < WAVE_DEPTH; i++) begin
            expected[v][i] = rand_byte();
            write_reg(wave_addr(v, i), expected[v][i]);
        end
    end
    for (int v = 0; v < NUM_VOICES; v++) begin
        for (int i = 0; i < WAVE_DEPTH; i++) begin
            read_reg(wave_addr(v, i), rd);
            check_byte($sformatf("voice %0d entry %0d", v, i), expected[v][i], rd);
        end
    end
    end_test();
endtask

task automatic test_constant_mix();
    logic [DATA_W-1:0] rd;
    start_test("constant_mix");
    for (int v = 0; v < NUM_VOICES; v++) begin
        for (int i = 0; i < WAVE_DEPTH; i++) begin
            write_reg(wave_addr(v, i), mix_level[v]);
        end
        write_reg(reg_addr(SEL_VOL + 4'(v)), {4'h0, mix_vol[v]});
    end
    write_reg(reg_addr(SEL_MUTE), 8'h07);
    wait_sound_value(expected_mix(3'b111), 20);
    check_sound("sum of three voices", expected_mix(3'b111), o_sound);
    // A non-wave read clears the byte left by a table read
    read_reg(wave_addr(2, 0), rd);
    check_byte("voice 2 entry 0", mix_level[2], rd);
    read_reg(reg_addr(SEL_VOL), rd);
    check_byte("read of 0x8A after a table read", 8'h00, rd);
    end_test();
endtask

task automatic test_mute_voice();
    start_test("mute_voice");
    write_reg(reg_addr(SEL_MUTE), 8'h05);
    wait_sound_value(expected_mix(3'b101), 20);
    check_sound("voice 1 muted", expected_mix(3'b101), o_sound);
    write_reg(reg_addr(SEL_MUTE), 8'h07);
    wait_sound_value(expected_mix(3'b111), 20);
    check_sound("voice 1 restored", expected_mix(3'b111), o_sound);
    end_test();
endtask

task automatic measure_steps(input int period);
    int cycles;
    write_reg(reg_addr(SEL_FREQ_HI), DATA_W'(period >> 8));
    write_reg(reg_addr(SEL_FREQ_LO), DATA_W'(period));
    // Let steps from the old period leave the three-stage pipe
    repeat (4) begin
        @(posedge emuclk);
        #10;
    end
    wait_sound_change(2 * period + 8, cycles);
    repeat (2) begin
        wait_sound_change(2 * period + 8, cycles);
        check_cycles($sformatf("step interval at period %0d", period), period + 1, cycles);
    end
endtask

task automatic test_period_steps();
    start_test("period_steps");
    write_reg(reg_addr(SEL_MUTE), 8'h01);
    write_reg(reg_addr(SEL_VOL), 8'h0F);
    for (int i = 0; i < WAVE_DEPTH; i++) begin
        write_reg(wave_addr(0, i), i[0] ? 8'hC0 : 8'h40);
    end
    measure_steps(5);
    measure_steps(20);
    end_test();
endtask

`endif

// ==== testbench/tb_scc_player.sv ====
`default_nettype none

module tb_scc_player;

    timeunit 1ns;
    timeprecision 100ps;

    import scc_bus_pkg::*;
    import scc_voice_pkg::*;

    logic                    emuclk;
    logic                    rst_n;
    logic                    i_wr;
    logic                    i_rd;
    scc_addr_t               i_addr;
    logic [DATA_W-1:0]       i_data;
    logic [DATA_W-1:0]       o_db;
    logic signed [MIX_W-1:0] o_sound;

    int          n_errors;
    int          n_checks;
    int          n_tests;
    int          err_base;
    string       cur_test;
    logic [31:0] lfsr_state;

    scc_player dut0 (
        .emuclk  (emuclk),
        .rst_n   (rst_n),
        .i_wr    (i_wr),
        .i_rd    (i_rd),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .o_db    (o_db),
        .o_sound (o_sound)
    );

    bind scc_player scc_player_props u_props (
        .emuclk   (emuclk),
        .rst_n    (rst_n),
        .i_rd     (i_rd),
        .i_mute_n (mute_n),
        .i_db     (o_db),
        .i_sound  (o_sound)
    );

    // 100 ns period
    initial emuclk = 1'b0;
    always #50 emuclk = ~emuclk;

    ////////////////////////////////////////
    // Stimulus helpers

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [DATA_W-1:0] rand_byte();
        logic [DATA_W-1:0] b;
        b = '0;
        for (int k = 0; k < DATA_W; k++) begin
            b = {b[DATA_W-2:0], lfsr_bit()};
        end
        return b;
    endfunction

    function automatic scc_addr_t wave_addr(input int voice, input int index);
        scc_addr_t a;
        a.wave.region = REGION_WAVE0 + 3'(voice);
        a.wave.index  = IDX_W'(index);
        return a;
    endfunction

    function automatic scc_addr_t reg_addr(input logic [3:0] sel);
        scc_addr_t a;
        a.regs.region = REGION_CTRL;
        a.regs.unused = 1'b0;
        a.regs.sel    = sel;
        return a;
    endfunction

    // Floor of sample * vol / 16, or zero when muted
    function automatic int scaled_value(input logic [SAMPLE_W-1:0] sample,
                                        input logic [VOL_W-1:0] vol, input logic en);
        int prod;
        prod = int'($signed(sample)) * int'(vol);
        return en ? (prod >>> 4) : 0;
    endfunction

    ////////////////////////////////////////
    // Bus tasks, entered 10 ns after a rising edge

    task automatic write_reg(input scc_addr_t addr, input logic [DATA_W-1:0] data);
        i_addr = addr;
        i_data = data;
        i_wr   = 1'b1;
        @(posedge emuclk);
        #10;
        i_wr   = 1'b0;
    endtask

    task automatic read_reg(input scc_addr_t addr, output logic [DATA_W-1:0] data);
        i_addr = addr;
        i_rd   = 1'b1;
        @(posedge emuclk);
        #10;
        i_rd   = 1'b0;
        // Byte reaches o_db one edge after the RAM read
        @(posedge emuclk);
        #10;
        data = o_db;
    endtask

    ////////////////////////////////////////
    // Compare tasks and bookkeeping

    task automatic check_byte(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s %s: expected 0x%02h, actual 0x%02h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic check_sound(input string what, input logic signed [MIX_W-1:0] exp,
                               input logic signed [MIX_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_cycles(input string what, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == err_base) begin
            $display("%-16s ok", cur_test);
        end else begin
            $display("%-16s %0d errors", cur_test, n_errors - err_base);
        end
    endtask

    `include "tb_scc_tests.svh"

    ////////////////////////////////////////
    // Sequence

    initial begin
        rst_n      = 1'b0;
        i_wr       = 1'b0;
        i_rd       = 1'b0;
        i_addr     = '0;
        i_data     = '0;
        n_errors   = 0;
        n_checks   = 0;
        n_tests    = 0;
        err_base   = 0;
        lfsr_state = 32'h935d_50a1;

        repeat (16) @(posedge emuclk);
        #10;
        rst_n = 1'b1;

        test_reset_state();
        test_wave_readback();
        test_constant_mix();
        test_mute_voice();
        test_period_steps();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/scc_bus_pkg.sv ====
`default_nettype none

package scc_bus_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 8;

    ////////////////////////////////////////
    // Address regions, upper three bits

    // Wavetables at 0x00, 0x20 and 0x40
    localparam logic [2:0] REGION_WAVE0 = 3'd0;
    localparam logic [2:0] REGION_WAVE1 = 3'd1;
    localparam logic [2:0] REGION_WAVE2 = 3'd2;

    // Register block at 0x80
    localparam logic [2:0] REGION_CTRL  = 3'd4;

    ////////////////////////////////////////
    // Selects inside the register block

    // Voice n adds 2n to the frequency selects and n to the volume select
    localparam logic [3:0] SEL_FREQ_LO  = 4'h0;
    localparam logic [3:0] SEL_FREQ_HI  = 4'h1;
    localparam logic [3:0] SEL_VOL      = 4'hA;
    localparam logic [3:0] SEL_MUTE     = 4'hF;

    // One address byte, seen as a table slot or as a register select
    typedef union packed {
        struct packed {
            logic [2:0]        region;
            logic [ADDR_W-4:0] index;
        } wave;
        struct packed {
            logic [2:0]        region;
            logic              unused;
            logic [ADDR_W-5:0] sel;
        } regs;
    } scc_addr_t;

endpackage

`default_nettype wire

// ==== verilog/scc_mixer.sv ====
`default_nettype none

module scc_mixer (
    input  logic                                                           emuclk,
    input  logic                                                           rst_n,
    input  logic [scc_voice_pkg::NUM_VOICES-1:0][scc_voice_pkg::SAMPLE_W-1:0] i_scaled,
    input  logic [scc_voice_pkg::NUM_VOICES-1:0][scc_voice_pkg::SAMPLE_W-1:0] i_cpu_q,
    input  logic [scc_voice_pkg::NUM_VOICES:0]                             i_rd_sel,
    output logic signed [scc_voice_pkg::MIX_W-1:0]                         o_sound,
    output logic [scc_bus_pkg::DATA_W-1:0]                                 o_db
);

    import scc_bus_pkg::*;
    import scc_voice_pkg::*;

    logic signed [MIX_W-1:0] sum;
    logic [DATA_W-1:0]       rd_byte;

    ////////////////////////////////////////
    // Voice sum

    always_comb begin
        sum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            sum = sum + {{(MIX_W - SAMPLE_W){i_scaled[v][SAMPLE_W-1]}}, i_scaled[v]};
        end
    end

    ////////////////////////////////////////
    // Readback byte

    // Select is one-hot over the voices
    always_comb begin
        rd_byte = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (i_rd_sel[v]) begin
                rd_byte = i_cpu_q[v];
            end
        end
    end

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_sound <= '0;
            o_db    <= '0;
        end else begin
            o_sound <= sum;
            // Holds between reads, a non-wave read gives 0x00
            if (|i_rd_sel) begin
                o_db <= rd_byte;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/scc_player.sv ====
`default_nettype none

module scc_player (
    input  logic                                   emuclk,
    input  logic                                   rst_n,
    input  logic                                   i_wr,
    input  logic                                   i_rd,
    input  scc_bus_pkg::scc_addr_t                 i_addr,
    input  logic [scc_bus_pkg::DATA_W-1:0]         i_data,
    output logic [scc_bus_pkg::DATA_W-1:0]         o_db,
    output logic signed [scc_voice_pkg::MIX_W-1:0] o_sound
);

    import scc_voice_pkg::*;

    logic [NUM_VOICES-1:0]                wave_we;
    logic [IDX_W-1:0]                     wave_idx;
    logic [SAMPLE_W-1:0]                  wave_d;
    logic [NUM_VOICES-1:0]                period_ld;
    logic [NUM_VOICES-1:0][PERIOD_W-1:0]  period;
    logic [NUM_VOICES-1:0][VOL_W-1:0]     vol;
    logic [NUM_VOICES-1:0]                mute_n;
    logic [NUM_VOICES:0]                  rd_sel;
    logic [NUM_VOICES-1:0][SAMPLE_W-1:0]  cpu_q;
    logic [NUM_VOICES-1:0][SAMPLE_W-1:0]  scaled;

    ////////////////////////////////////////
    // CPU port decode

    scc_reg_decode u_reg_decode (
        .emuclk      (emuclk),
        .rst_n       (rst_n),
        .i_wr        (i_wr),
        .i_rd        (i_rd),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .o_wave_we   (wave_we),
        .o_wave_idx  (wave_idx),
        .o_wave_d    (wave_d),
        .o_period_ld (period_ld),
        .o_period    (period),
        .o_vol       (vol),
        .o_mute_n    (mute_n),
        .o_rd_sel    (rd_sel)
    );

    ////////////////////////////////////////
    // Voices

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        scc_voice u_voice (
            .emuclk      (emuclk),
            .rst_n       (rst_n),
            .i_wave_we   (wave_we[v]),
            .i_wave_idx  (wave_idx),
            .i_wave_d    (wave_d),
            .i_period_ld (period_ld[v]),
            .i_period    (period[v]),
            .i_vol       (vol[v]),
            .i_mute_n    (mute_n[v]),
            .o_cpu_q     (cpu_q[v]),
            .o_scaled    (scaled[v])
        );
    end

    ////////////////////////////////////////
    // Sum and readback

    scc_mixer u_mixer (
        .emuclk   (emuclk),
        .rst_n    (rst_n),
        .i_scaled (scaled),
        .i_cpu_q  (cpu_q),
        .i_rd_sel (rd_sel),
        .o_sound  (o_sound),
        .o_db     (o_db)
    );

endmodule

`default_nettype wire

// ==== verilog/scc_reg_decode.sv ====
`default_nettype none

module scc_reg_decode (
    input  logic                                                          emuclk,
    input  logic                                                          rst_n,
    input  logic                                                          i_wr,
    input  logic                                                          i_rd,
    input  scc_bus_pkg::scc_addr_t                                        i_addr,
    input  logic [scc_bus_pkg::DATA_W-1:0]                                i_data,
    output logic [scc_voice_pkg::NUM_VOICES-1:0]                          o_wave_we,
    output logic [scc_voice_pkg::IDX_W-1:0]                               o_wave_idx,
    output logic [scc_voice_pkg::SAMPLE_W-1:0]                            o_wave_d,
    output logic [scc_voice_pkg::NUM_VOICES-1:0]                          o_period_ld,
    output logic [scc_voice_pkg::NUM_VOICES-1:0][scc_voice_pkg::PERIOD_W-1:0] o_period,
    output logic [scc_voice_pkg::NUM_VOICES-1:0][scc_voice_pkg::VOL_W-1:0]    o_vol,
    output logic [scc_voice_pkg::NUM_VOICES-1:0]                          o_mute_n,
    output logic [scc_voice_pkg::NUM_VOICES:0]                            o_rd_sel
);

    import scc_bus_pkg::*;
    import scc_voice_pkg::*;

    logic [NUM_VOICES-1:0] wave_hit;
    logic                  ctrl_hit;
    logic [3:0]            sel;
    logic [NUM_VOICES-1:0] freq_lo_wr;
    logic [NUM_VOICES-1:0] freq_hi_wr;
    logic [NUM_VOICES-1:0] vol_wr;
    logic                  mute_wr;
    logic [NUM_VOICES:0]   rd_sel_next;

    ////////////////////////////////////////
    // Address decode

    // Table regions through the wave view
    assign wave_hit[0] = (i_addr.wave.region == REGION_WAVE0);
    assign wave_hit[1] = (i_addr.wave.region == REGION_WAVE1);
    assign wave_hit[2] = (i_addr.wave.region == REGION_WAVE2);

    // Register block through the reg view
    assign ctrl_hit = (i_addr.regs.region == REGION_CTRL);
    assign sel      = i_addr.regs.sel;

    // Table writes land at this edge
    assign o_wave_we  = wave_hit & {NUM_VOICES{i_wr}};
    assign o_wave_idx = i_addr.wave.index;
    assign o_wave_d   = i_data;

    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            freq_lo_wr[v] = i_wr && ctrl_hit && (sel == 4'(SEL_FREQ_LO + 2 * v));
            freq_hi_wr[v] = i_wr && ctrl_hit && (sel == 4'(SEL_FREQ_HI + 2 * v));
            vol_wr[v]     = i_wr && ctrl_hit && (sel == 4'(SEL_VOL + v));
        end
    end

    assign mute_wr = i_wr && ctrl_hit && (sel == SEL_MUTE);

    // Top bit marks a read outside all tables
    assign rd_sel_next = {i_rd && !(|wave_hit), wave_hit & {NUM_VOICES{i_rd}}};

    ////////////////////////////////////////
    // Held registers

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_period    <= '0;
            o_vol       <= '0;
            o_mute_n    <= '0;
            o_period_ld <= '0;
            o_rd_sel    <= '0;
        end else begin
            // Counter reload one cycle on, once the new period is held
            o_period_ld <= freq_lo_wr | freq_hi_wr;
            // Lines up with the registered RAM read
            o_rd_sel    <= rd_sel_next;

            for (int v = 0; v < NUM_VOICES; v++) begin
                if (freq_lo_wr[v]) begin
                    o_period[v][DATA_W-1:0] <= i_data;
                end
                if (freq_hi_wr[v]) begin
                    o_period[v][PERIOD_W-1:DATA_W] <= i_data[PERIOD_W-DATA_W-1:0];
                end
                if (vol_wr[v]) begin
                    o_vol[v] <= i_data[VOL_W-1:0];
                end
            end

            if (mute_wr) begin
                o_mute_n <= i_data[NUM_VOICES-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/scc_voice.sv ====
`default_nettype none

module scc_voice (
    input  logic                                      emuclk,
    input  logic                                      rst_n,
    input  logic                                      i_wave_we,
    input  logic [scc_voice_pkg::IDX_W-1:0]           i_wave_idx,
    input  logic [scc_voice_pkg::SAMPLE_W-1:0]        i_wave_d,
    input  logic                                      i_period_ld,
    input  logic [scc_voice_pkg::PERIOD_W-1:0]        i_period,
    input  logic [scc_voice_pkg::VOL_W-1:0]           i_vol,
    input  logic                                      i_mute_n,
    output logic [scc_voice_pkg::SAMPLE_W-1:0]        o_cpu_q,
    output logic signed [scc_voice_pkg::SAMPLE_W-1:0] o_scaled
);

    import scc_voice_pkg::*;

    logic [PERIOD_W-1:0]             cnt;
    logic [IDX_W-1:0]                idx;
    logic [SAMPLE_W-1:0]             play_q;
    logic signed [SAMPLE_W+VOL_W:0]  product;
    logic signed [SAMPLE_W+VOL_W:0]  shifted;

    ////////////////////////////////////////
    // Period counter and wave index

    // One index step every period + 1 cycles
    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            idx <= '0;
        end else if (i_period_ld) begin
            // Frequency write restarts the count, index untouched
            cnt <= i_period;
        end else if (cnt == '0) begin
            cnt <= i_period;
            idx <= idx + 1'b1;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    ////////////////////////////////////////
    // Wavetable

    scc_wave_ram u_wave_ram (
        .emuclk     (emuclk),
        .i_we       (i_wave_we),
        .i_cpu_idx  (i_wave_idx),
        .i_cpu_d    (i_wave_d),
        .i_play_idx (idx),
        .o_cpu_q    (o_cpu_q),
        .o_play_q   (play_q)
    );

    ////////////////////////////////////////
    // Volume scaling

    // Volume is unsigned, zero-extended before the signed multiply
    always_comb begin
        product = $signed(play_q) * $signed({1'b0, i_vol});
        shifted = product >>> VOL_W;
    end

    // Floor of sample * vol / 16 always fits the sample width
    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_scaled <= '0;
        end else if (i_mute_n) begin
            o_scaled <= shifted[SAMPLE_W-1:0];
        end else begin
            o_scaled <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/scc_voice_pkg.sv ====
`default_nettype none

package scc_voice_pkg;

    ////////////////////////////////////////
    // Voice and wavetable sizes

    localparam int NUM_VOICES = 3;
    localparam int WAVE_DEPTH = 32;
    localparam int IDX_W      = 5;

    ////////////////////////////////////////
    // Datapath widths

    // Signed two's complement sample
    localparam int SAMPLE_W   = 8;
    localparam int VOL_W      = 4;

    // Reload value of the period counter
    localparam int PERIOD_W   = 12;

    // Three scaled samples, each within -120..119
    localparam int MIX_W      = 10;

endpackage

`default_nettype wire

// ==== verilog/scc_wave_ram.sv ====
`default_nettype none

module scc_wave_ram (
    input  logic                                emuclk,
    input  logic                                i_we,
    input  logic [scc_voice_pkg::IDX_W-1:0]     i_cpu_idx,
    input  logic [scc_voice_pkg::SAMPLE_W-1:0]  i_cpu_d,
    input  logic [scc_voice_pkg::IDX_W-1:0]     i_play_idx,
    output logic [scc_voice_pkg::SAMPLE_W-1:0]  o_cpu_q,
    output logic [scc_voice_pkg::SAMPLE_W-1:0]  o_play_q
);

    import scc_voice_pkg::*;

    logic [SAMPLE_W-1:0] mem [WAVE_DEPTH];

    ////////////////////////////////////////
    // CPU port

    // Read returns the old entry during a write
    always_ff @(posedge emuclk) begin
        if (i_we) begin
            mem[i_cpu_idx] <= i_cpu_d;
        end
        o_cpu_q <= mem[i_cpu_idx];
    end

    ////////////////////////////////////////
    // Playback port

    always_ff @(posedge emuclk) begin
        o_play_q <= mem[i_play_idx];
    end

endmodule

`default_nettype wire
